// File: files.f
+incdir+source
source/tap_state_pkg.sv
source/tap_instr_pkg.sv
source/tap_fsm.sv
source/tap_irreg.sv
source/tap_dr.sv
source/tap_tdo_mux.sv
source/tap_top.sv
tests/tap_tb.sv

// File: tests/tap_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "tap_macros.svh"

module tap_tb
   import tap_state_pkg::*, tap_instr_pkg::*;
   ;

   // Cycle budget for any wait loop
   localparam int WAIT_LIMIT = 20;

   logic       ftap_tck;
   logic       powergood_rst_trst_b;
   logic       ftap_tms;
   logic       ftap_tdi;
   idcode_t    slvidcode;
   logic       tdo;
   logic       tdo_en;
   user_data_t user_data;

   // Testbench view of where a shift window lies
   logic       in_shift;
   integer     seed;
   int         value_errors;
   int         timeout_errors;
   user_data_t user_model;

   tap_top i_tap_top (
      .ftap_tck             (ftap_tck),
      .powergood_rst_trst_b (powergood_rst_trst_b),
      .ftap_tms             (ftap_tms),
      .ftap_tdi             (ftap_tdi),
      .slvidcode            (slvidcode),
      .tdo                  (tdo),
      .tdo_en               (tdo_en),
      .user_data            (user_data)
   );

   // 10 ns clock
   initial
   begin
      ftap_tck = 1'b0;
      forever #5 ftap_tck = ~ftap_tck;
   end

   // *******************************************************************
   // Concurrent checks
   // *******************************************************************
   // Enable follows the shift window one half cycle late on both ends
   a_tdo_en_window: assert property (@(posedge ftap_tck)
      disable iff (!powergood_rst_trst_b)
      tdo_en == in_shift)
      else
      begin
         value_errors++;
         $display("Error at %0t: tdo_en is %b, expected %b", $time, tdo_en, in_shift);
      end

   // Quiet pin and cleared user register while in reset
   a_reset_quiet: assert property (@(posedge ftap_tck)
      !powergood_rst_trst_b |-> (!tdo_en && user_data == '0))
      else
      begin
         value_errors++;
         $display("Error at %0t: outputs active during reset", $time);
      end

   // *******************************************************************
   // Helpers
   // *******************************************************************
   task automatic check_bits(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
      a_value: assert (got === exp)
         else
         begin
            value_errors++;
            $display("Error at %0t: %s returned %h, expected %h", $time, what, got, exp);
         end
   endtask

   // One TCK cycle with tms set up on the falling edge
   task automatic clock_tms(input logic tms_val);
      @(negedge ftap_tck);
      ftap_tms = tms_val;
      @(posedge ftap_tck);
   endtask

   task automatic wait_tdo_en_low();
      int cycles;
      cycles = 0;
      while (tdo_en !== 1'b0 && cycles < WAIT_LIMIT)
      begin
         @(posedge ftap_tck);
         cycles++;
      end
      if (tdo_en !== 1'b0)
      begin
         timeout_errors++;
         $display("Timeout: tdo_en stayed high after the scan ended");
      end
   endtask

   task automatic wait_user_data(input user_data_t exp);
      int cycles;
      cycles = 0;
      while (user_data !== exp && cycles < WAIT_LIMIT)
      begin
         @(posedge ftap_tck);
         cycles++;
      end
      if (user_data !== exp)
      begin
         timeout_errors++;
         $display("Timeout: user_data never took the written value %h", exp);
      end
   endtask

   // Shift n bits LSB first from a Shift state then pass Update back to idle
   task automatic shift_bits(input int n, input logic [63:0] din,
                             output logic [63:0] dout);
      int i;
      dout = '0;
      for (i = 0; i < n; i++)
      begin
         @(negedge ftap_tck);
         in_shift = 1'b1;
         ftap_tdi = din[i];
         // Last bit leaves Shift while still shifting
         ftap_tms = (i == n - 1);
         @(posedge ftap_tck);
         dout[i] = tdo;
      end
      // Exit1 to Update
      @(negedge ftap_tck);
      in_shift = 1'b0;
      ftap_tms = 1'b1;
      @(posedge ftap_tck);
      // Update to idle
      clock_tms(1'b0);
      wait_tdo_en_low();
   endtask

   // Scan from idle through Shift-DR and back
   task automatic dr_scan(input int n, input logic [63:0] din,
                          output logic [63:0] dout);
      clock_tms(1'b1);
      clock_tms(1'b0);
      clock_tms(1'b0);
      shift_bits(n, din, dout);
   endtask

   // Load an opcode through Shift-IR and return to idle
   task automatic ir_scan(input tap_instr_t opc, output logic [63:0] dout);
      clock_tms(1'b1);
      clock_tms(1'b1);
      clock_tms(1'b0);
      clock_tms(1'b0);
      shift_bits(`TAP_IR_WIDTH, 64'(opc), dout);
   endtask

   function automatic logic [63:0] random_bits();
      return {$random(seed), $random(seed)};
   endfunction

   // *******************************************************************
   // Stimulus
   // *******************************************************************
   initial
   begin
      logic [63:0] din;
      logic [63:0] got;
      tap_instr_t  rand_opc;
      user_data_t  wr_value;

      seed                 = 32'h3b11d46f;
      value_errors         = 0;
      timeout_errors       = 0;
      in_shift             = 1'b0;
      ftap_tms             = 1'b1;
      ftap_tdi             = 1'b0;
      powergood_rst_trst_b <= 1'b0;
      slvidcode            = idcode_t'($random(seed));
      slvidcode.marker     = 1'b1;
      user_model           = '0;

      // Reset for 4 cycles and released on a falling edge
      repeat (4) @(posedge ftap_tck);
      @(negedge ftap_tck);
      powergood_rst_trst_b = 1'b1;
      check_bits("tdo_en after reset", 64'(tdo_en), 64'd0);
      check_bits("user_data after reset", 64'(user_data), 64'd0);
      clock_tms(1'b0);

      // Default instruction reads the strap
      dr_scan(32, random_bits(), got);
      check_bits("slvidcode scan", got, 64'(slvidcode));

      // IR capture pattern and then IDCODE
      ir_scan(`TAP_OPC_IDCODE, got);
      check_bits("IR capture", 64'(got[1:0]), 64'd1);
      dr_scan(32, random_bits(), got);
      check_bits("IDCODE scan", got, 64'(`TAP_IDCODE_VALUE));

      // ***************************************************************
      // Bypass by its opcode and by an unknown one
      // ***************************************************************
      ir_scan(`TAP_OPC_BYPASS, got);
      din = random_bits();
      dr_scan(24, din, got);
      check_bits("bypass stream", got, 64'({din[22:0], 1'b0}));

      rand_opc = tap_instr_t'($random(seed));
      if (rand_opc == `TAP_OPC_IDCODE || rand_opc == `TAP_OPC_SLVIDCODE ||
          rand_opc == `TAP_OPC_USERDATA || rand_opc == `TAP_OPC_BYPASS)
         rand_opc = tap_instr_t'(8'h5A);
      ir_scan(rand_opc, got);
      din = random_bits();
      dr_scan(24, din, got);
      check_bits("unknown opcode stream", got, 64'({din[22:0], 1'b0}));

      // ***************************************************************
      // User register write and read back
      // ***************************************************************
      ir_scan(`TAP_OPC_USERDATA, got);
      wr_value = user_data_t'($random(seed));
      dr_scan(`TAP_USER_WIDTH, 64'(wr_value), got);
      check_bits("user first read", got, 64'(user_model));
      user_model = wr_value;
      wait_user_data(user_model);

      wr_value = user_data_t'($random(seed));
      dr_scan(`TAP_USER_WIDTH, 64'(wr_value), got);
      check_bits("user read back", got, 64'(user_model));
      user_model = wr_value;
      wait_user_data(user_model);

      // ***************************************************************
      // Five tms-high cycles out of Shift-DR
      // ***************************************************************
      ir_scan(`TAP_OPC_IDCODE, got);
      clock_tms(1'b1);
      clock_tms(1'b0);
      clock_tms(1'b0);
      // One cycle in Shift-DR and out on the first tms high
      @(negedge ftap_tck);
      in_shift = 1'b1;
      ftap_tms = 1'b1;
      @(posedge ftap_tck);
      @(negedge ftap_tck);
      in_shift = 1'b0;
      @(posedge ftap_tck);
      repeat (3) clock_tms(1'b1);
      clock_tms(1'b0);
      check_bits("user_data kept", 64'(user_data), 64'(user_model));
      dr_scan(32, random_bits(), got);
      check_bits("slvidcode after tms reset", got, 64'(slvidcode));

      $display("Summary: %0d value errors, %0d timeouts", value_errors, timeout_errors);
      if (value_errors == 0 && timeout_errors == 0)
      begin
         $display("TEST OK");
      end
      else
      begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: source/tap_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "tap_macros.svh"

module tap_top
   import tap_instr_pkg::*;
   (
   input  logic       ftap_tck,
   input  logic       powergood_rst_trst_b,
   input  logic       ftap_tms,
   input  logic       ftap_tdi,
   input  idcode_t    slvidcode,
   output logic       tdo,
   output logic       tdo_en,
   output user_data_t user_data
   );

   // *******************************************************************
   // Internal nets
   // *******************************************************************
   logic        tlrs;
   logic        capture_ir;
   logic        shift_ir;
   logic        update_ir;
   logic [3:0]  capture_dr;
   logic [3:0]  shift_dr;
   logic [3:0]  update_dr;
   tap_dr_sel_t dr_sel;
   logic        shift_any;
   tap_instr_t  ireg;
   logic        ir_serial;
   logic [3:0]  dr_serial;

   // Bypass slot, the bit itself lives in the mux
   assign dr_serial[DR_SEL_BYPASS] = 1'b0;

   // Controller
   tap_fsm i_tap_fsm (
      .ftap_tck             (ftap_tck),
      .powergood_rst_trst_b (powergood_rst_trst_b),
      .ftap_tms             (ftap_tms),
      .ireg                 (ireg),
      .tlrs                 (tlrs),
      .capture_ir           (capture_ir),
      .shift_ir             (shift_ir),
      .update_ir            (update_ir),
      .capture_dr           (capture_dr),
      .shift_dr             (shift_dr),
      .update_dr            (update_dr),
      .dr_sel               (dr_sel),
      .shift_any            (shift_any)
   );

   // Instruction register
   tap_irreg i_tap_irreg (
      .ftap_tck             (ftap_tck),
      .powergood_rst_trst_b (powergood_rst_trst_b),
      .ftap_tdi             (ftap_tdi),
      .tlrs                 (tlrs),
      .capture_ir           (capture_ir),
      .shift_ir             (shift_ir),
      .update_ir            (update_ir),
      .ireg                 (ireg),
      .ir_serial            (ir_serial)
   );

   // *******************************************************************
   // Data registers
   // *******************************************************************
   tap_dr #(.payload_t(idcode_t), .has_update(1'b0)) i_dr_idcode (
      .ftap_tck             (ftap_tck),
      .powergood_rst_trst_b (powergood_rst_trst_b),
      .ftap_tdi             (ftap_tdi),
      .tlrs                 (tlrs),
      .capture              (capture_dr[DR_SEL_IDCODE]),
      .shift                (shift_dr[DR_SEL_IDCODE]),
      .update               (update_dr[DR_SEL_IDCODE]),
      .capture_value        (idcode_t'(`TAP_IDCODE_VALUE)),
      .dr_serial            (dr_serial[DR_SEL_IDCODE]),
      .update_value         ()
   );

   // Strap value from the integration level
   tap_dr #(.payload_t(idcode_t), .has_update(1'b0)) i_dr_slvidcode (
      .ftap_tck             (ftap_tck),
      .powergood_rst_trst_b (powergood_rst_trst_b),
      .ftap_tdi             (ftap_tdi),
      .tlrs                 (tlrs),
      .capture              (capture_dr[DR_SEL_SLVIDCODE]),
      .shift                (shift_dr[DR_SEL_SLVIDCODE]),
      .update               (update_dr[DR_SEL_SLVIDCODE]),
      .capture_value        (slvidcode),
      .dr_serial            (dr_serial[DR_SEL_SLVIDCODE]),
      .update_value         ()
   );

   // Read back of the last written value
   tap_dr #(.payload_t(user_data_t), .has_update(1'b1)) i_dr_user (
      .ftap_tck             (ftap_tck),
      .powergood_rst_trst_b (powergood_rst_trst_b),
      .ftap_tdi             (ftap_tdi),
      .tlrs                 (tlrs),
      .capture              (capture_dr[DR_SEL_USERDATA]),
      .shift                (shift_dr[DR_SEL_USERDATA]),
      .update               (update_dr[DR_SEL_USERDATA]),
      .capture_value        (user_data),
      .dr_serial            (dr_serial[DR_SEL_USERDATA]),
      .update_value         (user_data)
   );

   // Output path
   tap_tdo_mux i_tap_tdo_mux (
      .ftap_tck             (ftap_tck),
      .powergood_rst_trst_b (powergood_rst_trst_b),
      .ftap_tdi             (ftap_tdi),
      .shift_ir             (shift_ir),
      .shift_any            (shift_any),
      .capture_bypass       (capture_dr[DR_SEL_BYPASS]),
      .shift_bypass         (shift_dr[DR_SEL_BYPASS]),
      .dr_sel               (dr_sel),
      .ir_serial            (ir_serial),
      .dr_serial            (dr_serial),
      .tdo                  (tdo),
      .tdo_en               (tdo_en)
   );

endmodule

`default_nettype wire

// File: source/tap_tdo_mux.sv
`timescale 1ns/100ps
`default_nettype none

module tap_tdo_mux
   import tap_instr_pkg::*;
   (
   input  logic        ftap_tck,
   input  logic        powergood_rst_trst_b,
   input  logic        ftap_tdi,
   input  logic        shift_ir,
   input  logic        shift_any,
   input  logic        capture_bypass,
   input  logic        shift_bypass,
   input  tap_dr_sel_t dr_sel,
   input  logic        ir_serial,
   input  logic [3:0]  dr_serial,
   output logic        tdo,
   output logic        tdo_en
   );

   logic bypass_bit;
   logic tdo_nxt;

   // *******************************************************************
   // Bypass register
   // *******************************************************************
   always_ff @(posedge ftap_tck or negedge powergood_rst_trst_b)
   begin
      if (!powergood_rst_trst_b)
      begin
         bypass_bit <= 1'b0;
      end
      else if (capture_bypass)
      begin
         bypass_bit <= 1'b0;
      end
      else if (shift_bypass)
      begin
         bypass_bit <= ftap_tdi;
      end
   end

   // IR path wins while shifting instructions
   always_comb
   begin
      if (shift_ir)
         tdo_nxt = ir_serial;
      else if (dr_sel == DR_SEL_BYPASS)
         tdo_nxt = bypass_bit;
      else
         tdo_nxt = dr_serial[dr_sel];
   end

   // *******************************************************************
   // Falling-edge retiming of pin and enable
   // *******************************************************************
   always_ff @(negedge ftap_tck or negedge powergood_rst_trst_b)
   begin
      if (!powergood_rst_trst_b)
      begin
         tdo    <= 1'b0;
         tdo_en <= 1'b0;
      end
      else
      begin
         tdo_en <= shift_any;
         // Pin keeps its last value between scans
         if (shift_any)
            tdo <= tdo_nxt;
      end
   end

endmodule

`default_nettype wire

// File: source/tap_dr.sv
`timescale 1ns/100ps
`default_nettype none

module tap_dr
   #(
   parameter type payload_t  = logic [7:0],
   parameter bit  has_update = 1'b0
   )
   (
   input  logic     ftap_tck,
   input  logic     powergood_rst_trst_b,
   input  logic     ftap_tdi,
   input  logic     tlrs,
   input  logic     capture,
   input  logic     shift,
   input  logic     update,
   input  payload_t capture_value,
   output logic     dr_serial,
   output payload_t update_value
   );

   localparam int WIDTH = $bits(payload_t);

   logic [WIDTH-1:0] shift_reg;

   // *******************************************************************
   // Capture and shift, rising edge
   // *******************************************************************
   always_ff @(posedge ftap_tck or negedge powergood_rst_trst_b)
   begin
      if (!powergood_rst_trst_b)
      begin
         shift_reg <= '0;
      end
      else if (tlrs)
      begin
         shift_reg <= '0;
      end
      else if (capture)
      begin
         shift_reg <= capture_value;
      end
      else if (shift)
      begin
         // LSB first out, tdi fills from the top
         shift_reg <= {ftap_tdi, shift_reg[WIDTH-1:1]};
      end
   end

   assign dr_serial = shift_reg[0];

   // *******************************************************************
   // Optional parallel stage, falling edge
   // *******************************************************************
   generate
      if (has_update)
      begin : g_update
         // Held through test logic reset, only power-good clears it
         always_ff @(negedge ftap_tck or negedge powergood_rst_trst_b)
         begin
            if (!powergood_rst_trst_b)
            begin
               update_value <= '0;
            end
            else if (update)
            begin
               update_value <= payload_t'(shift_reg);
            end
         end
      end
      else
      begin : g_no_update
         // Read-only register, the shift stage is all there is
         assign update_value = payload_t'(shift_reg);
      end
   endgenerate

endmodule

`default_nettype wire

// File: source/tap_irreg.sv
`timescale 1ns/100ps
`default_nettype none

`include "tap_macros.svh"

module tap_irreg
   import tap_instr_pkg::*;
   (
   input  logic       ftap_tck,
   input  logic       powergood_rst_trst_b,
   input  logic       ftap_tdi,
   input  logic       tlrs,
   input  logic       capture_ir,
   input  logic       shift_ir,
   input  logic       update_ir,
   output tap_instr_t ireg,
   output logic       ir_serial
   );

   // *******************************************************************
   // Constants
   // *******************************************************************
   // Mandatory 01 pattern in the lowest bits on capture
   localparam tap_instr_t IR_CAPTURE_VALUE = {{(`TAP_IR_WIDTH-2){1'b0}}, 2'b01};
   // Instruction in force after reset
   localparam tap_instr_t IR_RESET_VALUE   = `TAP_OPC_SLVIDCODE;

   tap_instr_t shift_reg;

   // *******************************************************************
   // Shift stage, rising edge
   // *******************************************************************
   always_ff @(posedge ftap_tck or negedge powergood_rst_trst_b)
   begin
      if (!powergood_rst_trst_b)
      begin
         shift_reg <= IR_CAPTURE_VALUE;
      end
      else if (tlrs || capture_ir)
      begin
         shift_reg <= IR_CAPTURE_VALUE;
      end
      else if (shift_ir)
      begin
         // tdi enters at the top, LSB leaves first
         shift_reg <= {ftap_tdi, shift_reg[`TAP_IR_WIDTH-1:1]};
      end
   end

   // Serial bit towards the TDO mux
   assign ir_serial = shift_reg[0];

   // *******************************************************************
   // Shadow stage, falling edge
   // *******************************************************************
   // Stable for a full half cycle before the decode sees it
   always_ff @(negedge ftap_tck or negedge powergood_rst_trst_b)
   begin
      if (!powergood_rst_trst_b)
      begin
         ireg <= IR_RESET_VALUE;
      end
      else if (tlrs)
      begin
         ireg <= IR_RESET_VALUE;
      end
      else if (update_ir)
      begin
         ireg <= shift_reg;
      end
   end

   // *******************************************************************
   // Assertions
   // *******************************************************************
   a_cap_shift_excl: assert property (@(posedge ftap_tck)
      disable iff (!powergood_rst_trst_b)
      !(capture_ir && shift_ir));

endmodule

`default_nettype wire

// File: source/tap_fsm.sv
`timescale 1ns/100ps
`default_nettype none

`include "tap_macros.svh"

module tap_fsm
   import tap_state_pkg::*, tap_instr_pkg::*;
   (
   input  logic        ftap_tck,
   input  logic        powergood_rst_trst_b,
   input  logic        ftap_tms,
   input  tap_instr_t  ireg,
   output logic        tlrs,
   output logic        capture_ir,
   output logic        shift_ir,
   output logic        update_ir,
   output logic [3:0]  capture_dr,
   output logic [3:0]  shift_dr,
   output logic [3:0]  update_dr,
   output tap_dr_sel_t dr_sel,
   output logic        shift_any
   );

   tap_state_t state;
   tap_state_t state_nxt;

   // *******************************************************************
   // State register
   // *******************************************************************
   always_ff @(posedge ftap_tck or negedge powergood_rst_trst_b)
   begin
      if (!powergood_rst_trst_b)
      begin
         state <= ST_TLRS;
      end
      else
      begin
         state <= state_nxt;
      end
   end

   // Standard 1149.1 transition table
   always_comb
   begin
      case (state)
         ST_TLRS     : state_nxt = ftap_tms ? ST_TLRS     : ST_RTI;
         ST_RTI      : state_nxt = ftap_tms ? ST_SEL_DR   : ST_RTI;
         ST_SEL_DR   : state_nxt = ftap_tms ? ST_SEL_IR   : ST_CAP_DR;
         ST_CAP_DR   : state_nxt = ftap_tms ? ST_EXIT1_DR : ST_SHIFT_DR;
         ST_SHIFT_DR : state_nxt = ftap_tms ? ST_EXIT1_DR : ST_SHIFT_DR;
         ST_EXIT1_DR : state_nxt = ftap_tms ? ST_UPD_DR   : ST_PAUSE_DR;
         ST_PAUSE_DR : state_nxt = ftap_tms ? ST_EXIT2_DR : ST_PAUSE_DR;
         ST_EXIT2_DR : state_nxt = ftap_tms ? ST_UPD_DR   : ST_SHIFT_DR;
         ST_UPD_DR   : state_nxt = ftap_tms ? ST_SEL_DR   : ST_RTI;
         ST_SEL_IR   : state_nxt = ftap_tms ? ST_TLRS     : ST_CAP_IR;
         ST_CAP_IR   : state_nxt = ftap_tms ? ST_EXIT1_IR : ST_SHIFT_IR;
         ST_SHIFT_IR : state_nxt = ftap_tms ? ST_EXIT1_IR : ST_SHIFT_IR;
         ST_EXIT1_IR : state_nxt = ftap_tms ? ST_UPD_IR   : ST_PAUSE_IR;
         ST_PAUSE_IR : state_nxt = ftap_tms ? ST_EXIT2_IR : ST_PAUSE_IR;
         ST_EXIT2_IR : state_nxt = ftap_tms ? ST_UPD_IR   : ST_SHIFT_IR;
         ST_UPD_IR   : state_nxt = ftap_tms ? ST_SEL_DR   : ST_RTI;
         default     : state_nxt = ST_TLRS;
      endcase
   end

   // *******************************************************************
   // State strobes, level for the whole cycle
   // *******************************************************************
   assign tlrs       = (state == ST_TLRS);
   assign capture_ir = (state == ST_CAP_IR);
   assign shift_ir   = (state == ST_SHIFT_IR);
   assign update_ir  = (state == ST_UPD_IR);
   assign shift_any  = shift_ir | (state == ST_SHIFT_DR);

   // Opcode decode, unknown opcodes fall back to bypass
   always_comb
   begin
      case (ireg)
         `TAP_OPC_IDCODE    : dr_sel = DR_SEL_IDCODE;
         `TAP_OPC_SLVIDCODE : dr_sel = DR_SEL_SLVIDCODE;
         `TAP_OPC_USERDATA  : dr_sel = DR_SEL_USERDATA;
         `TAP_OPC_BYPASS    : dr_sel = DR_SEL_BYPASS;
         default            : dr_sel = DR_SEL_BYPASS;
      endcase
   end

   // DR strobes steered to the selected register only
   always_comb
   begin
      capture_dr         = '0;
      shift_dr           = '0;
      update_dr          = '0;
      capture_dr[dr_sel] = (state == ST_CAP_DR);
      shift_dr[dr_sel]   = (state == ST_SHIFT_DR);
      update_dr[dr_sel]  = (state == ST_UPD_DR);
   end

   // *******************************************************************
   // Assertions
   // *******************************************************************
   a_state_known: assert property (@(posedge ftap_tck) disable iff (!powergood_rst_trst_b)
      !$isunknown(state));

   a_dr_strobe_onehot: assert property (@(posedge ftap_tck)
      disable iff (!powergood_rst_trst_b)
      $onehot0(capture_dr) && $onehot0(shift_dr) && $onehot0(update_dr));

   // Five tms-high edges land in reset from anywhere
   a_tms_reset: assert property (@(posedge ftap_tck) disable iff (!powergood_rst_trst_b)
      ftap_tms [*5] |=> (state == ST_TLRS));

endmodule

`default_nettype wire

// File: source/tap_instr_pkg.sv
`default_nettype none

`include "tap_macros.svh"

package tap_instr_pkg;

   // *******************************************************************
   // Instruction word
   // *******************************************************************
   typedef logic [`TAP_IR_WIDTH-1:0] tap_instr_t;

   // *******************************************************************
   // Data register selection
   // *******************************************************************
   // Values double as bit index into the per-register strobe vectors
   typedef enum logic [1:0]
   {
      DR_SEL_BYPASS    = 2'd0,
      DR_SEL_IDCODE    = 2'd1,
      DR_SEL_SLVIDCODE = 2'd2,
      DR_SEL_USERDATA  = 2'd3
   } tap_dr_sel_t;

   // *******************************************************************
   // Payloads
   // *******************************************************************
   // Layout shared by both ID registers
   typedef struct packed
   {
      logic [3:0]  version;
      logic [15:0] part;
      logic [10:0] manufacturer;
      logic        marker;
   } idcode_t;

   typedef logic [`TAP_USER_WIDTH-1:0] user_data_t;

endpackage

`default_nettype wire

// File: source/tap_state_pkg.sv
`default_nettype none

package tap_state_pkg;

   // *******************************************************************
   // TAP controller states
   // *******************************************************************
   // All sixteen codes are used, so no illegal encoding exists
   typedef enum logic [3:0]
   {
      ST_TLRS      = 4'hF,
      ST_RTI       = 4'hC,
      // DR column
      ST_SEL_DR    = 4'h7,
      ST_CAP_DR    = 4'h6,
      ST_SHIFT_DR  = 4'h2,
      ST_EXIT1_DR  = 4'h1,
      ST_PAUSE_DR  = 4'h3,
      ST_EXIT2_DR  = 4'h0,
      ST_UPD_DR    = 4'h5,
      // IR column
      ST_SEL_IR    = 4'h4,
      ST_CAP_IR    = 4'hE,
      ST_SHIFT_IR  = 4'hA,
      ST_EXIT1_IR  = 4'h9,
      ST_PAUSE_IR  = 4'hB,
      ST_EXIT2_IR  = 4'h8,
      ST_UPD_IR    = 4'hD
   } tap_state_t;

endpackage

`default_nettype wire

// File: source/tap_macros.svh
`ifndef TAP_MACROS_SVH
`define TAP_MACROS_SVH

// Instruction register length
`define TAP_IR_WIDTH 8

// Opcode table
// Anything not listed here decodes to bypass
`define TAP_OPC_IDCODE    8'h02
`define TAP_OPC_SLVIDCODE 8'h0C
`define TAP_OPC_USERDATA  8'h10
`define TAP_OPC_BYPASS    8'hFF

// Fixed device identification, bit 0 is the mandatory marker
`define TAP_IDCODE_VALUE 32'h0A25_1013

// User data register length
`define TAP_USER_WIDTH 16

`endif
